/* list.f */
verilog/host_cmd_pkg.sv
verilog/bridge_regs.sv
verilog/cmd_decode.sv
verilog/cmd_execute.sv
verilog/cmd_result.sv
verilog/host_cmd_top.sv
sim/host_cmd_checker.sv
sim/tb_host_cmd.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_host_cmd -f list.f
out=$(./obj_dir/Vtb_host_cmd +verilator+error+limit+100 || true)
echo "$out"
if echo "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1

/* sim/host_cmd_checker.sv */
// protocol checks on the core-facing side of the host command handler
// requests held until acknowledged, rtc_valid sticky, and an OK
// status word only right after the execute stage completes
`timescale 1ns/1ns

module host_cmd_checker (
    input logic        clk,
    input logic        arst_n,
    input logic        dataslot_requestread,
    input logic        dataslot_requestread_ack,
    input logic        savestate_start,
    input logic        savestate_start_ack,
    input logic        rtc_valid,
    input logic        exe_done,
    input logic [31:0] status_word
);

    int   fail_count = 0;
    logic ok_word;

    assign ok_word = (status_word[31:16] == host_cmd_pkg::OK_MAGIC);

    slot_req_held: assert property (@(posedge clk) disable iff (!arst_n)
        (dataslot_requestread && !dataslot_requestread_ack) |=> dataslot_requestread)
        else begin
            $error("dataslot request dropped without ack");
            fail_count++;
        end

    save_req_held: assert property (@(posedge clk) disable iff (!arst_n)
        (savestate_start && !savestate_start_ack) |=> savestate_start)
        else begin
            $error("savestate start dropped without ack");
            fail_count++;
        end

    // rtc data stays valid once delivered
    rtc_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        rtc_valid |=> rtc_valid)
        else begin
            $error("rtc_valid fell");
            fail_count++;
        end

    ok_after_done: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(ok_word) |-> $past(exe_done))
        else begin
            $error("OK status without exe_done");
            fail_count++;
        end

endmodule

bind host_cmd_top host_cmd_checker u_host_cmd_checker (
    .clk                      (clk),
    .arst_n                   (arst_n),
    .dataslot_requestread     (dataslot_requestread),
    .dataslot_requestread_ack (dataslot_requestread_ack),
    .savestate_start          (savestate_start),
    .savestate_start_ack      (savestate_start_ack),
    .rtc_valid                (rtc_valid),
    .exe_done                 (exe_done),
    .status_word              (status_word)
);

/* sim/tb_host_cmd.sv */
// testbench for the host command handler
// drives bridge writes and reads, answers core requests after
// random delays and checks result codes and core-facing outputs
`timescale 1ns/1ns

module tb_host_cmd;

    localparam int CLK_PERIOD      = 20;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;

    logic        clk, arst_n;
    logic        bridge_endian_little, bridge_rd, bridge_wr;
    logic [7:0]  bridge_addr;
    logic [31:0] bridge_rd_data, bridge_wr_data;
    logic        status_boot_done, status_setup_done, status_running;
    logic        reset_out, dataslot_requestread, dataslot_allcomplete;
    logic        dataslot_requestread_ack, dataslot_requestread_ok;
    logic [15:0] dataslot_requestread_id;
    logic [31:0] rtc_epoch_seconds, rtc_date_bcd, rtc_time_bcd;
    logic        rtc_valid, osnotify_inmenu;
    logic        savestate_supported, savestate_start, savestate_start_ack;
    logic        savestate_start_busy, savestate_start_ok, savestate_start_err;
    logic [31:0] savestate_addr, savestate_size;

    int          errors, checks, test_num, test_errors, i;
    logic [31:0] rng_state, pval, rd_word;
    logic [31:0] rtc_vals [3];
    logic [15:0] result;

    host_cmd_top #(.SLOT_ID_W(16)) u_host_cmd_top (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(CLK_PERIOD * CYCLES_PER_TEST * NUM_TESTS);
        $display("watchdog expired, tests did not finish in %0d cycles",
                 CYCLES_PER_TEST * NUM_TESTS);
        $display("TEST FAILED");
        $finish;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] swap_bytes(input logic [31:0] w);
        return {<<8{w}};
    endfunction

    // index is {boot, setup, running}
    function automatic logic [15:0] status_expect(input logic [2:0] s);
        case (s)
            3'b100:         return 16'd2;
            3'b101:         return 16'd4;
            3'b110, 3'b111: return 16'd3;
            default:        return 16'd1;  // still booting
        endcase
    endfunction

    // index is {err, ok, busy}
    function automatic logic [15:0] save_expect(input logic [2:0] f);
        casez (f)
            3'b1??:  return 16'd3;
            3'b01?:  return 16'd2;
            3'b001:  return 16'd1;
            default: return 16'd0;
        endcase
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic bridge_write(input logic [7:0] addr, input logic [31:0] data);
        bridge_addr    = addr;
        bridge_wr_data = data;
        bridge_wr      = 1'b1;
        @(negedge clk);
        bridge_wr = 1'b0;
    endtask

    task automatic bridge_read(input logic [7:0] addr, output logic [31:0] data);
        bridge_addr = addr;
        bridge_rd   = 1'b1;
        @(negedge clk);
        bridge_rd = 1'b0;
        data      = bridge_rd_data;  // registered read data holds until the next read
    endtask

    task automatic wait_ok(output logic [15:0] code);
        logic [31:0] word;
        int          polls;
        word  = 32'h0;
        polls = 0;
        while (word[31:16] != host_cmd_pkg::OK_MAGIC && polls < 40) begin
            bridge_read(host_cmd_pkg::REG_STATUS, word);
            polls++;
        end
        if (word[31:16] != host_cmd_pkg::OK_MAGIC) begin
            $display("status word never showed OK within %0d polls", polls);
            errors++;
        end
        code = word[15:0];
    endtask

    task automatic send_cmd(input logic [15:0] code);
        bridge_write(host_cmd_pkg::REG_STATUS, {host_cmd_pkg::CMD_MAGIC, code});
    endtask

    task automatic run_cmd(input logic [15:0] code, output logic [15:0] res);
        send_cmd(code);
        @(negedge clk);  // skip the stale word of the previous command
        wait_ok(res);
    endtask

    task automatic wait_request(input logic save);
        int n;
        n = 0;
        while (!(save ? savestate_start : dataslot_requestread) && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!(save ? savestate_start : dataslot_requestread)) begin
            $display("core request was never raised");
            errors++;
        end
    endtask

    task automatic ack_request(input logic save);
        rng_state = lcg_next(rng_state);
        repeat (rng_state[18:16]) @(negedge clk);  // 0 to 7 cycles of core delay
        if (save) savestate_start_ack = 1'b1;
        else dataslot_requestread_ack = 1'b1;
        @(negedge clk);
        savestate_start_ack      = 1'b0;
        dataslot_requestread_ack = 1'b0;
    endtask

    task automatic end_test(input string name);
        test_num++;
        $display("test %0d %s finished with %0d errors", test_num, name, errors - test_errors);
        test_errors = errors;
    endtask

    initial begin
        errors = 0;
        checks = 0;
        test_num = 0;
        test_errors = 0;
        rng_state = 32'd6249;
        arst_n = 1'b0;
        bridge_endian_little = 1'b0;
        bridge_addr = 8'h0;
        bridge_rd = 1'b0;
        bridge_wr = 1'b0;
        bridge_wr_data = 32'h0;
        {status_boot_done, status_setup_done, status_running} = 3'b000;
        dataslot_requestread_ack = 1'b0;
        dataslot_requestread_ok = 1'b0;
        savestate_supported = 1'b0;
        savestate_addr = 32'h0;
        savestate_size = 32'h0;
        savestate_start_ack = 1'b0;
        {savestate_start_err, savestate_start_ok, savestate_start_busy} = 3'b000;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        for (i = 0; i < 8; i++) begin
            {status_boot_done, status_setup_done, status_running} = i[2:0];
            run_cmd(host_cmd_pkg::CODE_STATUS, result);
            check_eq(32'(result), 32'(status_expect(i[2:0])), "status result");
        end
        end_test("request status");

        check_eq(32'(reset_out), 32'd0, "reset_out after reset");
        run_cmd(host_cmd_pkg::CODE_RESET_EXIT, result);
        check_eq(32'(result), 32'd0, "reset exit result");
        check_eq(32'(reset_out), 32'd1, "reset_out after exit");
        run_cmd(host_cmd_pkg::CODE_RESET_ENTER, result);
        check_eq(32'(result), 32'd0, "reset enter result");
        check_eq(32'(reset_out), 32'd0, "reset_out after enter");
        end_test("reset enter and exit");

        run_cmd(host_cmd_pkg::CODE_ALL_COMPLETE, result);
        check_eq(32'(dataslot_allcomplete), 32'd1, "allcomplete before read");
        for (i = 0; i < 2; i++) begin
            rng_state = lcg_next(rng_state);
            pval = rng_state;
            bridge_write(host_cmd_pkg::REG_PARAM0, pval);
            dataslot_requestread_ok = (i == 0);
            send_cmd(host_cmd_pkg::CODE_SLOT_READ);
            wait_request(1'b0);
            check_eq(32'(dataslot_requestread_id), {16'h0, pval[15:0]}, "slot id");
            bridge_read(host_cmd_pkg::REG_STATUS, rd_word);
            check_eq(rd_word, {host_cmd_pkg::BUSY_MAGIC, host_cmd_pkg::CODE_SLOT_READ},
                     "busy word while waiting");
            ack_request(1'b0);
            wait_ok(result);
            check_eq(32'(result), (i == 0) ? 32'd0 : 32'd2, "slot read result");
            check_eq(32'(dataslot_requestread), 32'd0, "slot request after ack");
            check_eq(32'(dataslot_allcomplete), 32'd0, "allcomplete after read");
        end
        run_cmd(host_cmd_pkg::CODE_ALL_COMPLETE, result);
        check_eq(32'(dataslot_allcomplete), 32'd1, "allcomplete set again");
        end_test("data slot read");

        for (i = 0; i < 3; i++) begin
            rng_state = lcg_next(rng_state);
            rtc_vals[i] = rng_state;
            bridge_write(host_cmd_pkg::REG_PARAM0 + 8'(i * 4), rtc_vals[i]);
        end
        run_cmd(host_cmd_pkg::CODE_RTC, result);
        check_eq(rtc_epoch_seconds, rtc_vals[0], "rtc epoch");
        check_eq(rtc_date_bcd, rtc_vals[1], "rtc date");
        check_eq(rtc_time_bcd, rtc_vals[2], "rtc time");
        check_eq(32'(rtc_valid), 32'd1, "rtc_valid");
        bridge_write(host_cmd_pkg::REG_PARAM0, 32'h0000_0001);
        run_cmd(host_cmd_pkg::CODE_MENU, result);
        check_eq(32'(osnotify_inmenu), 32'd1, "menu entered");
        bridge_write(host_cmd_pkg::REG_PARAM0, 32'hFFFF_FFFE);
        run_cmd(host_cmd_pkg::CODE_MENU, result);
        check_eq(32'(osnotify_inmenu), 32'd0, "menu left");
        end_test("rtc and menu");

        savestate_supported = 1'b1;
        savestate_addr = lcg_next(rng_state);
        savestate_size = lcg_next(savestate_addr);
        bridge_write(host_cmd_pkg::REG_PARAM0, 32'h0);
        for (i = 0; i < 8; i++) begin
            {savestate_start_err, savestate_start_ok, savestate_start_busy} = i[2:0];
            run_cmd(host_cmd_pkg::CODE_SAVE_START, result);
            check_eq(32'(result), 32'(save_expect(i[2:0])), "savestate query result");
        end
        bridge_read(host_cmd_pkg::REG_RESP0, rd_word);
        check_eq(rd_word, 32'd1, "resp0 supported");
        bridge_read(host_cmd_pkg::REG_RESP1, rd_word);
        check_eq(rd_word, savestate_addr, "resp1 addr");
        bridge_read(host_cmd_pkg::REG_RESP2, rd_word);
        check_eq(rd_word, savestate_size, "resp2 size");
        {savestate_start_err, savestate_start_ok, savestate_start_busy} = 3'b000;
        bridge_write(host_cmd_pkg::REG_PARAM0, 32'h0000_0001);
        send_cmd(host_cmd_pkg::CODE_SAVE_START);
        wait_request(1'b1);
        savestate_start_ok = 1'b1;
        ack_request(1'b1);
        wait_ok(result);
        check_eq(32'(result), 32'd2, "savestate start result");
        check_eq(32'(savestate_start), 32'd0, "savestate start after ack");
        savestate_start_ok = 1'b0;
        run_cmd(16'h1234, result);
        check_eq(32'(result), 32'(host_cmd_pkg::RESULT_UNKNOWN), "unknown code result");
        end_test("savestate and unknown");

        bridge_read(host_cmd_pkg::REG_STATUS, rd_word);  // big endian view
        bridge_endian_little = 1'b1;
        repeat (3) @(negedge clk);  // through the synchronizer
        bridge_read(host_cmd_pkg::REG_STATUS, pval);
        check_eq(pval, swap_bytes(rd_word), "status little endian");
        bridge_write(host_cmd_pkg::REG_PARAM1, 32'h1122_3344);
        bridge_read(host_cmd_pkg::REG_PARAM1, rd_word);
        check_eq(rd_word, 32'h1122_3344, "param1 round trip");
        bridge_endian_little = 1'b0;
        repeat (3) @(negedge clk);
        bridge_read(host_cmd_pkg::REG_PARAM1, rd_word);
        check_eq(rd_word, 32'h4433_2211, "param1 big endian view");
        end_test("endian swap");

        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 test_num, checks, errors, u_host_cmd_top.u_host_cmd_checker.fail_count);
        if (errors == 0 && u_host_cmd_top.u_host_cmd_checker.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verilog/bridge_regs.sv */
// bridge register window for host commands
// endian swap on both data paths, parameter registers,
// registered read mux and detection of "CM" command writes
`timescale 1ns/1ns

module bridge_regs (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        bridge_endian_little,
    input  logic [7:0]  bridge_addr,
    input  logic        bridge_rd,
    output logic [31:0] bridge_rd_data,
    input  logic        bridge_wr,
    input  logic [31:0] bridge_wr_data,
    input  logic [31:0] status_word,
    input  logic [31:0] resp0,
    input  logic [31:0] resp1,
    input  logic [31:0] resp2,
    output logic [31:0] param0,
    output logic [31:0] param1,
    output logic [31:0] param2,
    output logic [31:0] param3,
    output logic        status_wr,
    output logic [31:0] status_wr_data,
    output logic        cmd_start,
    output logic [15:0] cmd_code
);

    logic        endian_meta;
    logic        endian_s;
    logic [31:0] wr_data_in;
    logic [31:0] rd_data_q;
    logic        wr_status;

    function automatic logic [31:0] byte_swap(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // endian select comes from the bridge side
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            endian_meta <= 1'b0;
            endian_s    <= 1'b0;
        end else begin
            endian_meta <= bridge_endian_little;
            endian_s    <= endian_meta;
        end
    end

    assign wr_data_in     = endian_s ? byte_swap(bridge_wr_data) : bridge_wr_data;
    assign bridge_rd_data = endian_s ? byte_swap(rd_data_q) : rd_data_q;

    assign wr_status = bridge_wr && (bridge_addr == host_cmd_pkg::REG_STATUS);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            status_wr <= 1'b0;
            cmd_start <= 1'b0;
        end else begin
            status_wr <= wr_status;
            cmd_start <= wr_status && (wr_data_in[31:16] == host_cmd_pkg::CMD_MAGIC);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_status) begin
            status_wr_data <= wr_data_in;
            cmd_code       <= wr_data_in[15:0];  // meaningful only with cmd_start
        end
        if (bridge_wr) begin
            case (bridge_addr)
                host_cmd_pkg::REG_PARAM0: param0 <= wr_data_in;
                host_cmd_pkg::REG_PARAM1: param1 <= wr_data_in;
                host_cmd_pkg::REG_PARAM2: param2 <= wr_data_in;
                host_cmd_pkg::REG_PARAM3: param3 <= wr_data_in;
                default: ;
            endcase
        end
        if (bridge_rd) begin
            case (bridge_addr)
                host_cmd_pkg::REG_STATUS: rd_data_q <= status_word;
                host_cmd_pkg::REG_PARAM0: rd_data_q <= param0;
                host_cmd_pkg::REG_PARAM1: rd_data_q <= param1;
                host_cmd_pkg::REG_PARAM2: rd_data_q <= param2;
                host_cmd_pkg::REG_PARAM3: rd_data_q <= param3;
                host_cmd_pkg::REG_RESP0:  rd_data_q <= resp0;
                host_cmd_pkg::REG_RESP1:  rd_data_q <= resp1;
                host_cmd_pkg::REG_RESP2:  rd_data_q <= resp2;
                default:                  rd_data_q <= 32'h0;  // unmapped offsets
            endcase
        end
    end

endmodule

/* verilog/cmd_decode.sv */
// host command decode
// latches a started command, maps its code to an opcode,
// issues it once and stays busy until execute completes
`timescale 1ns/1ns

module cmd_decode (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  cmd_start,
    input  logic [15:0]           cmd_code,
    input  logic                  exe_done,
    output logic                  op_valid,
    output host_cmd_pkg::cmd_op_t op,
    output logic                  busy_set,
    output logic [15:0]           busy_code
);

    host_cmd_pkg::dec_state_t state;
    host_cmd_pkg::cmd_op_t    op_map;
    logic                     accept;

    always_comb begin
        case (cmd_code)
            host_cmd_pkg::CODE_STATUS:       op_map = host_cmd_pkg::op_status;
            host_cmd_pkg::CODE_RESET_ENTER:  op_map = host_cmd_pkg::op_reset_enter;
            host_cmd_pkg::CODE_RESET_EXIT:   op_map = host_cmd_pkg::op_reset_exit;
            host_cmd_pkg::CODE_SLOT_READ:    op_map = host_cmd_pkg::op_slot_read;
            host_cmd_pkg::CODE_ALL_COMPLETE: op_map = host_cmd_pkg::op_all_complete;
            host_cmd_pkg::CODE_RTC:          op_map = host_cmd_pkg::op_rtc;
            host_cmd_pkg::CODE_SAVE_START:   op_map = host_cmd_pkg::op_save_start;
            host_cmd_pkg::CODE_MENU:         op_map = host_cmd_pkg::op_menu;
            default:                         op_map = host_cmd_pkg::op_unknown;
        endcase
    end

    // no queueing, a start while busy is dropped
    assign accept = cmd_start && (state == host_cmd_pkg::dec_idle);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= host_cmd_pkg::dec_idle;
        end else begin
            case (state)
                host_cmd_pkg::dec_idle:  if (accept) state <= host_cmd_pkg::dec_issue;
                host_cmd_pkg::dec_issue: state <= host_cmd_pkg::dec_busy;
                host_cmd_pkg::dec_busy:  if (exe_done) state <= host_cmd_pkg::dec_idle;
                default:                 state <= host_cmd_pkg::dec_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            busy_code <= cmd_code;
            op        <= op_map;
        end
    end

    assign op_valid = (state == host_cmd_pkg::dec_issue);
    assign busy_set = op_valid;  // busy word goes out with the issue

endmodule

/* verilog/cmd_execute.sv */
// host command execute stage
// drives the core-facing outputs per opcode, holds requests
// until the core acknowledges and produces the result code
`timescale 1ns/1ns

module cmd_execute #(
    parameter int SLOT_ID_W = 16
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  op_valid,
    input  host_cmd_pkg::cmd_op_t op,
    input  logic [31:0]           param0,
    input  logic [31:0]           param1,
    input  logic [31:0]           param2,
    input  logic [31:0]           param3,
    input  logic                  status_boot_done,
    input  logic                  status_setup_done,
    input  logic                  status_running,
    input  logic                  dataslot_requestread_ack,
    input  logic                  dataslot_requestread_ok,
    input  logic                  savestate_supported,
    input  logic [31:0]           savestate_addr,
    input  logic [31:0]           savestate_size,
    input  logic                  savestate_start_ack,
    input  logic                  savestate_start_busy,
    input  logic                  savestate_start_ok,
    input  logic                  savestate_start_err,
    output logic                  reset_out,
    output logic                  dataslot_requestread,
    output logic [SLOT_ID_W-1:0]  dataslot_requestread_id,
    output logic                  dataslot_allcomplete,
    output logic [31:0]           rtc_epoch_seconds,
    output logic [31:0]           rtc_date_bcd,
    output logic [31:0]           rtc_time_bcd,
    output logic                  rtc_valid,
    output logic                  savestate_start,
    output logic                  osnotify_inmenu,
    output logic                  exe_done,
    output logic [15:0]           exe_code,
    output logic                  resp_wr,
    output logic                  resp_supported,
    output logic [31:0]           resp_addr,
    output logic [31:0]           resp_size
);

    host_cmd_pkg::exe_state_t state;
    logic [15:0] status_code;
    logic [15:0] save_code;
    logic        start;
    logic        slot_ack;
    logic        save_ack;

    always_comb begin
        if (!status_boot_done)      status_code = 16'd1;  // booting
        else if (status_setup_done) status_code = 16'd3;  // idle
        else if (status_running)    status_code = 16'd4;
        else                        status_code = 16'd2;  // setup
    end

    // err wins over ok, ok over busy
    always_comb begin
        if (savestate_start_err)       save_code = 16'd3;
        else if (savestate_start_ok)   save_code = 16'd2;
        else if (savestate_start_busy) save_code = 16'd1;
        else                           save_code = 16'd0;
    end

    assign start    = op_valid && (state == host_cmd_pkg::exe_idle);
    assign slot_ack = dataslot_requestread && dataslot_requestread_ack;
    assign save_ack = savestate_start && savestate_start_ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state                <= host_cmd_pkg::exe_idle;
            reset_out            <= 1'b0;
            dataslot_requestread <= 1'b0;
            dataslot_allcomplete <= 1'b0;
            rtc_valid            <= 1'b0;
            savestate_start      <= 1'b0;
            osnotify_inmenu      <= 1'b0;
            resp_wr              <= 1'b0;
        end else begin
            resp_wr <= 1'b0;
            case (state)
                host_cmd_pkg::exe_idle: if (start) begin
                    state <= host_cmd_pkg::exe_done;  // immediate unless overridden
                    case (op)
                        host_cmd_pkg::op_reset_enter:  reset_out <= 1'b0;
                        host_cmd_pkg::op_reset_exit:   reset_out <= 1'b1;
                        host_cmd_pkg::op_all_complete: dataslot_allcomplete <= 1'b1;
                        host_cmd_pkg::op_rtc:          rtc_valid <= 1'b1;
                        host_cmd_pkg::op_menu:         osnotify_inmenu <= param0[0];
                        host_cmd_pkg::op_slot_read: begin
                            dataslot_allcomplete <= 1'b0;
                            dataslot_requestread <= 1'b1;
                            state                <= host_cmd_pkg::exe_wait_ack;
                        end
                        host_cmd_pkg::op_save_start: begin
                            resp_wr <= 1'b1;
                            if (param0[0]) begin  // start requested, not just a query
                                savestate_start <= 1'b1;
                                state           <= host_cmd_pkg::exe_wait_ack;
                            end
                        end
                        default: ;
                    endcase
                end
                host_cmd_pkg::exe_wait_ack: begin
                    if (slot_ack || save_ack) begin
                        dataslot_requestread <= 1'b0;
                        savestate_start      <= 1'b0;
                        state                <= host_cmd_pkg::exe_done;
                    end
                end
                host_cmd_pkg::exe_done: state <= host_cmd_pkg::exe_idle;
                default:                state <= host_cmd_pkg::exe_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            exe_code <= 16'h0000;
            case (op)
                host_cmd_pkg::op_status:    exe_code <= status_code;
                host_cmd_pkg::op_unknown:   exe_code <= host_cmd_pkg::RESULT_UNKNOWN;
                host_cmd_pkg::op_slot_read: dataslot_requestread_id <= param0[SLOT_ID_W-1:0];
                host_cmd_pkg::op_rtc: begin
                    rtc_epoch_seconds <= param0;
                    rtc_date_bcd      <= param1;
                    rtc_time_bcd      <= param2;
                end
                host_cmd_pkg::op_save_start: begin
                    exe_code       <= save_code;
                    resp_supported <= savestate_supported;
                    resp_addr      <= savestate_addr;
                    resp_size      <= savestate_size;
                end
                default: ;
            endcase
        end
        if (slot_ack) exe_code <= dataslot_requestread_ok ? 16'd0 : 16'd2;
        if (save_ack) exe_code <= save_code;  // flags as seen at the ack
    end

    assign exe_done = (state == host_cmd_pkg::exe_done);

endmodule

/* verilog/cmd_result.sv */
// host command result registers
// status word read back by the host, overwritten with "BU"
// while a command runs and "OK" plus result when it is done,
// and the savestate response words
`timescale 1ns/1ns

module cmd_result (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        status_wr,
    input  logic [31:0] status_wr_data,
    input  logic        busy_set,
    input  logic [15:0] busy_code,
    input  logic        exe_done,
    input  logic [15:0] exe_code,
    input  logic        resp_wr,
    input  logic        resp_supported,
    input  logic [31:0] resp_addr,
    input  logic [31:0] resp_size,
    output logic [31:0] status_word,
    output logic [31:0] resp0,
    output logic [31:0] resp1,
    output logic [31:0] resp2
);

    // completion beats busy beats a direct host write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            status_word <= 32'h0;
        end else if (exe_done) begin
            status_word <= {host_cmd_pkg::OK_MAGIC, exe_code};
        end else if (busy_set) begin
            status_word <= {host_cmd_pkg::BUSY_MAGIC, busy_code};
        end else if (status_wr) begin
            status_word <= status_wr_data;  // host command or scratch value
        end
    end

    // savestate query answer
    always_ff @(posedge clk) begin
        if (resp_wr) begin
            resp0 <= {31'h0, resp_supported};
            resp1 <= resp_addr;
            resp2 <= resp_size;
        end
    end

endmodule

/* verilog/host_cmd_pkg.sv */
// host command handler shared definitions
// decoded opcodes, FSM state types, status magic words,
// host command codes and host window register offsets
package host_cmd_pkg;

    // operations after decode
    typedef enum logic [3:0] {
        op_status,
        op_reset_enter,
        op_reset_exit,
        op_slot_read,
        op_all_complete,
        op_rtc,
        op_save_start,
        op_menu,
        op_unknown
    } cmd_op_t;

    typedef enum logic [1:0] {
        dec_idle,
        dec_issue,  // opcode handed to execute
        dec_busy
    } dec_state_t;

    typedef enum logic [1:0] {
        exe_idle,
        exe_wait_ack,  // request held for the core
        exe_done
    } exe_state_t;

    // upper half of the status word
    localparam logic [15:0] CMD_MAGIC  = 16'h434D;  // "CM"
    localparam logic [15:0] BUSY_MAGIC = 16'h4255;  // "BU"
    localparam logic [15:0] OK_MAGIC   = 16'h4F4B;  // "OK"

    localparam logic [15:0] RESULT_UNKNOWN = 16'hFFFF;

    // host command codes, lower half of a command word
    localparam logic [15:0] CODE_STATUS       = 16'h0000;
    localparam logic [15:0] CODE_RESET_ENTER  = 16'h0010;
    localparam logic [15:0] CODE_RESET_EXIT   = 16'h0011;
    localparam logic [15:0] CODE_SLOT_READ    = 16'h0080;
    localparam logic [15:0] CODE_ALL_COMPLETE = 16'h008F;
    localparam logic [15:0] CODE_RTC          = 16'h0090;
    localparam logic [15:0] CODE_SAVE_START   = 16'h00A0;
    localparam logic [15:0] CODE_MENU         = 16'h00B0;

    // host window offsets
    localparam logic [7:0] REG_STATUS = 8'h00;
    localparam logic [7:0] REG_PARAM0 = 8'h20;
    localparam logic [7:0] REG_PARAM1 = 8'h24;
    localparam logic [7:0] REG_PARAM2 = 8'h28;
    localparam logic [7:0] REG_PARAM3 = 8'h2C;
    localparam logic [7:0] REG_RESP0  = 8'h40;
    localparam logic [7:0] REG_RESP1  = 8'h44;
    localparam logic [7:0] REG_RESP2  = 8'h48;

endpackage

/* verilog/host_cmd_top.sv */
// host command handler, top level
// host writes parameters and a "CM" command word over the bridge,
// the command is decoded, executed against the core and answered
// with "BU" and then "OK" plus a result code in the status word
`timescale 1ns/1ns

module host_cmd_top #(
    parameter int SLOT_ID_W = 16
) (
    input  logic                 clk,
    input  logic                 arst_n,

    input  logic                 bridge_endian_little,
    input  logic [7:0]           bridge_addr,
    input  logic                 bridge_rd,
    output logic [31:0]          bridge_rd_data,
    input  logic                 bridge_wr,
    input  logic [31:0]          bridge_wr_data,

    input  logic                 status_boot_done,
    input  logic                 status_setup_done,
    input  logic                 status_running,

    output logic                 reset_out,
    output logic                 dataslot_requestread,
    output logic [SLOT_ID_W-1:0] dataslot_requestread_id,
    input  logic                 dataslot_requestread_ack,
    input  logic                 dataslot_requestread_ok,
    output logic                 dataslot_allcomplete,

    output logic [31:0]          rtc_epoch_seconds,
    output logic [31:0]          rtc_date_bcd,
    output logic [31:0]          rtc_time_bcd,
    output logic                 rtc_valid,

    input  logic                 savestate_supported,
    input  logic [31:0]          savestate_addr,
    input  logic [31:0]          savestate_size,
    output logic                 savestate_start,
    input  logic                 savestate_start_ack,
    input  logic                 savestate_start_busy,
    input  logic                 savestate_start_ok,
    input  logic                 savestate_start_err,

    output logic                 osnotify_inmenu
);

    logic [31:0] param0, param1, param2, param3;
    logic [31:0] status_word, resp0, resp1, resp2;
    logic        status_wr;
    logic [31:0] status_wr_data;
    logic        cmd_start;
    logic [15:0] cmd_code;
    logic        op_valid;
    host_cmd_pkg::cmd_op_t op;
    logic        busy_set;
    logic [15:0] busy_code;
    logic        exe_done;
    logic [15:0] exe_code;
    logic        resp_wr, resp_supported;
    logic [31:0] resp_addr, resp_size;

    bridge_regs u_bridge_regs (.*);

    cmd_decode u_cmd_decode (.*);

    cmd_execute #(
        .SLOT_ID_W (SLOT_ID_W)
    ) u_cmd_execute (.*);

    cmd_result u_cmd_result (.*);

endmodule
